// ==== decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit (
        input  logic          clk,
        input  logic          rst,
        input  mipsPkg::ifIdT ifIn,
        input  logic          wbWrite,
        input  logic [4:0]    wbReg,
        input  logic [31:0]   wbData,
        output mipsPkg::idExT idOut
);

        mipsPkg::opcodeT opcode;
        mipsPkg::functT  funct;
        mipsPkg::ctrlT   ctrl;
        mipsPkg::aluOpT  aluOp;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [15:0]     imm;
        logic [31:0]     regs [32];
        logic [31:0]     readData1;
        logic [31:0]     readData2;

        // Field split
        assign opcode = mipsPkg::opcodeT'(ifIn.instruction[31:26]);
        assign funct  = mipsPkg::functT'(ifIn.instruction[5:0]);
        assign rs     = ifIn.instruction[25:21];
        assign rt     = ifIn.instruction[20:16];
        assign imm    = ifIn.instruction[15:0];

        //////////////////////////////
        // Main controller
        //////////////////////////////
        always_comb begin
                ctrl  = '0;
                aluOp = mipsPkg::aluAdd;
                case (opcode)
                        mipsPkg::opRType: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.regDst   = 1'b1;
                                case (funct)
                                        mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
                                        mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
                                        mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
                                        mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
                                        mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
                                        mipsPkg::fnSll:  aluOp = mipsPkg::aluSll;
                                        // Unknown function retires as nop
                                        default: ctrl.regWrite = 1'b0;
                                endcase
                        end
                        mipsPkg::opAddiu: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                        end
                        mipsPkg::opAndi: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.zeroExt  = 1'b1;
                                aluOp         = mipsPkg::aluAnd;
                        end
                        mipsPkg::opOri: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.zeroExt  = 1'b1;
                                aluOp         = mipsPkg::aluOr;
                        end
                        mipsPkg::opLw: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.memRead  = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.wbSel    = mipsPkg::wbMem;
                        end
                        mipsPkg::opSw: begin
                                ctrl.memWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                        end
                        // Compare by subtraction, zero flag decides in MEM
                        mipsPkg::opBeq: begin
                                ctrl.branch = 1'b1;
                                aluOp       = mipsPkg::aluSub;
                        end
                        mipsPkg::opBne: begin
                                ctrl.branch   = 1'b1;
                                ctrl.branchNe = 1'b1;
                                aluOp         = mipsPkg::aluSub;
                        end
                        mipsPkg::opJ: begin
                                ctrl.jump = 1'b1;
                        end
                        mipsPkg::opJal: begin
                                ctrl.jump     = 1'b1;
                                ctrl.link     = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.wbSel    = mipsPkg::wbPc;
                        end
                        default: ctrl = '0;
                endcase
        end

        //////////////////////////////
        // Register file
        //////////////////////////////
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wbWrite && (wbReg != 5'd0)) begin
                        regs[wbReg] <= wbData;
                end
        end

        // r0 hardwired, same-cycle writeback bypassed
        always_comb begin
                if (rs == 5'd0) begin
                        readData1 = '0;
                end else if (wbWrite && (wbReg == rs)) begin
                        readData1 = wbData;
                end else begin
                        readData1 = regs[rs];
                end
                if (rt == 5'd0) begin
                        readData2 = '0;
                end else if (wbWrite && (wbReg == rt)) begin
                        readData2 = wbData;
                end else begin
                        readData2 = regs[rt];
                end
        end

        // Payload to ID/EX
        always_comb begin
                idOut           = '0;
                idOut.ctrl      = ctrl;
                idOut.aluOp     = aluOp;
                idOut.readData1 = readData1;
                idOut.readData2 = readData2;
                idOut.immediate = ctrl.zeroExt ? {16'd0, imm} : {{16{imm[15]}}, imm};
                idOut.shamt     = ifIn.instruction[10:6];
                idOut.rt        = rt;
                idOut.rd        = ifIn.instruction[15:11];
                idOut.pcPlus4   = ifIn.pcPlus4;
                // Region bits plus word-shifted index
                idOut.jumpTarget = {ifIn.pcPlus4[31:28], ifIn.instruction[25:0], 2'b00};
        end

        // EX drops writes that target r0, so none reaches the bypass
        regZeroRead: assert property (@(posedge clk) disable iff (rst)
                wbWrite |-> (wbReg != 5'd0));

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
        input  mipsPkg::idExT  idIn,
        output mipsPkg::exMemT exOut
);

        logic [31:0] opB;
        logic [31:0] aluResult;
        logic [4:0]  writeReg;

        //////////////////////////////
        // ALU control and ALU
        //////////////////////////////

        // Immediate for I-type, rt otherwise
        assign opB = idIn.ctrl.aluSrc ? idIn.immediate : idIn.readData2;

        always_comb begin
                case (idIn.aluOp)
                        mipsPkg::aluAdd: aluResult = idIn.readData1 + opB;
                        mipsPkg::aluSub: aluResult = idIn.readData1 - opB;
                        mipsPkg::aluAnd: aluResult = idIn.readData1 & opB;
                        mipsPkg::aluOr:  aluResult = idIn.readData1 | opB;
                        // Signed compare
                        mipsPkg::aluSlt: aluResult = {31'd0,
                                $signed(idIn.readData1) < $signed(opB)};
                        // Shifts rt by shamt, rs unused
                        mipsPkg::aluSll: aluResult = idIn.readData2 << idIn.shamt;
                        default:         aluResult = '0;
                endcase
        end

        // Destination, r31 for jal
        always_comb begin
                if (idIn.ctrl.link) begin
                        writeReg = 5'd31;
                end else if (idIn.ctrl.regDst) begin
                        writeReg = idIn.rd;
                end else begin
                        writeReg = idIn.rt;
                end
        end

        //////////////////////////////
        // Payload to EX/MEM
        //////////////////////////////
        always_comb begin
                exOut           = '0;
                exOut.ctrl      = idIn.ctrl;
                // Writes aimed at r0 retire as bubbles
                exOut.ctrl.regWrite = idIn.ctrl.regWrite && (writeReg != 5'd0);
                exOut.aluResult = aluResult;
                exOut.zero      = (aluResult == 32'd0);
                exOut.storeData = idIn.readData2;
                // Word offset relative to the delay-free PC+4
                exOut.branchTarget = idIn.pcPlus4 + {idIn.immediate[29:0], 2'b00};
                exOut.jumpTarget   = idIn.jumpTarget;
                exOut.pcPlus4      = idIn.pcPlus4;
                exOut.writeReg     = writeReg;
        end

endmodule

// ==== fetchUnit.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module fetchUnit (
        input  logic          clk,
        input  logic          rst,
        input  logic          run,
        input  logic          imemWe,
        input  logic [5:0]    imemAddr,
        input  logic [31:0]   imemData,
        input  logic          redirect,
        input  logic [31:0]   redirectPc,
        output logic [31:0]   ProgramCounter,
        output mipsPkg::ifIdT ifOut
);

        localparam int IdxW = $clog2(`MIPS_IMEM_WORDS);

        logic [31:0] imem [`MIPS_IMEM_WORDS];
        logic [31:0] pcPlus4;
        logic [31:0] instruction;

        assign pcPlus4 = ProgramCounter + 32'd4;

        // Word-indexed, combinational read
        assign instruction = imem[ProgramCounter[IdxW+1:2]];

        //////////////////////////////
        // Program counter
        //////////////////////////////
        always_ff @(posedge clk) begin
                if (rst) begin
                        ProgramCounter <= `MIPS_RESET_PC;
                end else if (redirect) begin
                        // Taken branch or jump from MEM
                        ProgramCounter <= redirectPc;
                end else if (run) begin
                        ProgramCounter <= pcPlus4;
                end
        end

        // Load port, one word per strobe
        always_ff @(posedge clk) begin
                if (imemWe) begin
                        imem[imemAddr] <= imemData;
                end
        end

        // Bubble into IF/ID while halted
        always_comb begin
                ifOut = '0;
                if (run) begin
                        ifOut.instruction = instruction;
                        ifOut.pcPlus4     = pcPlus4;
                end
        end

        // Redirect targets must keep fetch on word boundaries
        pcAligned: assert property (@(posedge clk) disable iff (rst)
                ProgramCounter[1:0] == 2'b00);

endmodule

// ==== memoryUnit.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module memoryUnit (
        input  logic           clk,
        input  logic           rst,
        input  mipsPkg::exMemT memIn,
        output mipsPkg::memWbT memOut,
        output logic           redirect,
        output logic [31:0]    redirectPc
);

        localparam int IdxW = $clog2(`MIPS_DMEM_WORDS);

        logic [31:0]     dmem [`MIPS_DMEM_WORDS];
        logic [IdxW-1:0] wordIdx;

        assign wordIdx = memIn.aluResult[IdxW+1:2];

        //////////////////////////////
        // Data memory
        //////////////////////////////

        // Store lands at the edge closing MEM
        always_ff @(posedge clk) begin
                if (memIn.ctrl.memWrite) begin
                        dmem[wordIdx] <= memIn.storeData;
                end
        end

        // Branch resolve, bne inverts the zero test
        assign redirect = memIn.ctrl.jump ||
                (memIn.ctrl.branch && (memIn.zero ^ memIn.ctrl.branchNe));
        assign redirectPc = memIn.ctrl.jump ? memIn.jumpTarget : memIn.branchTarget;

        // Payload to MEM/WB
        always_comb begin
                memOut           = '0;
                memOut.regWrite  = memIn.ctrl.regWrite;
                memOut.wbSel     = memIn.ctrl.wbSel;
                memOut.aluResult = memIn.aluResult;
                memOut.memData   = memIn.ctrl.memRead ? dmem[wordIdx] : 32'd0;
                memOut.pcPlus4   = memIn.pcPlus4;
                memOut.writeReg  = memIn.writeReg;
        end

        // Address from EX must hit an aligned word inside the array
        dmemAddrOk: assert property (@(posedge clk) disable iff (rst)
                (memIn.ctrl.memRead || memIn.ctrl.memWrite) |->
                ((memIn.aluResult[1:0] == 2'b00) &&
                 (memIn.aluResult < (`MIPS_DMEM_WORDS * 4))));

endmodule

// ==== mipsPkg.sv ====
package mipsPkg;

        // Supported primary opcodes
        typedef enum logic [5:0] {
                opRType = 6'd0,
                opJ     = 6'd2,
                opJal   = 6'd3,
                opBeq   = 6'd4,
                opBne   = 6'd5,
                opAddiu = 6'd9,
                opAndi  = 6'd12,
                opOri   = 6'd13,
                opLw    = 6'd35,
                opSw    = 6'd43
        } opcodeT;

        // Supported R-type function codes
        typedef enum logic [5:0] {
                fnSll  = 6'd0,
                fnAddu = 6'd33,
                fnSubu = 6'd35,
                fnAnd  = 6'd36,
                fnOr   = 6'd37,
                fnSlt  = 6'd42
        } functT;

        typedef enum logic [3:0] {
                aluAdd = 4'd0,
                aluSub = 4'd1,
                aluAnd = 4'd2,
                aluOr  = 4'd3,
                aluSlt = 4'd4,
                aluSll = 4'd5
        } aluOpT;

        // Writeback source
        typedef enum logic [1:0] {
                wbAlu = 2'd0,
                wbMem = 2'd1,
                wbPc  = 2'd2
        } wbSelT;

        //////////////////////////////
        // Control word, 12 bits
        //////////////////////////////
        typedef struct packed {
                logic  regWrite;
                logic  memRead;
                logic  memWrite;
                logic  aluSrc;
                logic  zeroExt;
                logic  branch;
                logic  branchNe;
                logic  jump;
                logic  link;
                logic  regDst;
                wbSelT wbSel;
        } ctrlT;

        //////////////////////////////
        // Stage payloads, all zero is a bubble
        //////////////////////////////
        typedef struct packed {
                logic [31:0] instruction;
                logic [31:0] pcPlus4;
        } ifIdT;

        typedef struct packed {
                ctrlT        ctrl;
                aluOpT       aluOp;
                logic [31:0] readData1;
                logic [31:0] readData2;
                logic [31:0] immediate;
                logic [4:0]  shamt;
                logic [4:0]  rt;
                logic [4:0]  rd;
                logic [31:0] pcPlus4;
                logic [31:0] jumpTarget;
        } idExT;

        typedef struct packed {
                ctrlT        ctrl;
                logic [31:0] aluResult;
                logic        zero;
                logic [31:0] storeData;
                logic [31:0] branchTarget;
                logic [31:0] jumpTarget;
                logic [31:0] pcPlus4;
                logic [4:0]  writeReg;
        } exMemT;

        typedef struct packed {
                logic        regWrite;
                wbSelT       wbSel;
                logic [31:0] aluResult;
                logic [31:0] memData;
                logic [31:0] pcPlus4;
                logic [4:0]  writeReg;
        } memWbT;

endpackage

// ==== mipsTb.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mipsTb;

        localparam int WatchCycles = (`MIPS_IMEM_WORDS + 20) * 4;
        localparam int Slots       = 12;

        typedef struct packed {
                logic [4:0]  dest;
                logic [31:0] value;
        } expWriteT;

        logic        clk;
        logic        rst;
        logic        run;
        logic        imemWe;
        logic [5:0]  imemAddr;
        logic [31:0] imemData;
        logic [31:0] ProgramCounter;
        logic [31:0] WriteData;
        logic        writeValid;
        logic [4:0]  writeReg;

        logic [31:0] lfsr;
        logic [31:0] prog [`MIPS_IMEM_WORDS];
        logic [31:0] regsM [32];
        logic [31:0] dmemM [`MIPS_DMEM_WORDS];
        logic [31:0] haltAddr;
        expWriteT    expQ [$];
        expWriteT    chk;
        logic        chkAvail;
        int          haltSeen;

        mipsTop i_mipsTop (
                .clk(clk), .rst(rst), .run(run),
                .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
                .ProgramCounter(ProgramCounter), .WriteData(WriteData),
                .writeValid(writeValid), .writeReg(writeReg)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        task automatic abortRun(input string why);
                $display("%s", why);
                $display("TB FAILED");
                $fatal(1, "Stopped at first error");
        endtask

        // Fibonacci LFSR, taps 32 22 2 1, one step per bit
        function automatic logic [31:0] takeBits(input int n);
                logic [31:0] v;
                logic        fb;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
                        lfsr = {lfsr[30:0], fb};
                        v    = {v[30:0], fb};
                end
                return v;
        endfunction

        //////////////////////////////
        // Instruction encoders
        //////////////////////////////
        function automatic logic [31:0] encR(input logic [4:0] rs, rt, rd, sh,
                                             input logic [5:0] fn);
                return {6'd0, rs, rt, rd, sh, fn};
        endfunction

        function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs, rt,
                                             input logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] idx);
                return {op, idx};
        endfunction

        //////////////////////////////
        // Program generator and ISA model
        //////////////////////////////

        // Slot k sits at word 4k, three nops after it
        task automatic buildProgram();
                int          nextSlot;
                int          m;
                logic [3:0]  kind;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [4:0]  rd;
                logic [4:0]  sh;
                logic [4:0]  dest;
                logic [15:0] imm;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] res;
                logic [31:0] addr;
                logic [31:0] word;
                logic [31:0] lastSw;
                logic        wr;
                logic        taken;
                logic        st;
                logic        haveSw;
                expWriteT    w;
                nextSlot = 0;
                haveSw   = 1'b0;
                lastSw   = '0;
                for (int i = 0; i < `MIPS_IMEM_WORDS; i++) begin
                        prog[i] = '0;
                end
                for (int i = 0; i < 32; i++) begin
                        regsM[i] = '0;
                end
                for (int k = 0; k < Slots; k++) begin
                        kind = 4'(takeBits(4));
                        // Small register set, so r0 and reuse show up
                        rs   = 5'(takeBits(3));
                        rt   = 5'(takeBits(3));
                        rd   = 5'(takeBits(3));
                        sh   = 5'(takeBits(5));
                        imm  = 16'(takeBits(16));
                        m    = k + 1 + int'(takeBits(2));
                        if (m > Slots) begin
                                m = Slots;
                        end
                        a     = regsM[rs];
                        b     = regsM[rt];
                        addr  = {25'd0, imm[4:0], 2'b00};
                        dest  = rd;
                        res   = '0;
                        wr    = 1'b1;
                        taken = 1'b0;
                        st    = 1'b0;
                        // No load before a store on the taken path
                        if (kind == 4'd10 && !haveSw) begin
                                kind = 4'd11;
                        end
                        case (kind)
                                4'd0: begin
                                        word = encR(rs, rt, rd, 5'd0, mipsPkg::fnAddu);
                                        res  = a + b;
                                end
                                4'd1: begin
                                        word = encR(rs, rt, rd, 5'd0, mipsPkg::fnSubu);
                                        res  = a - b;
                                end
                                4'd2: begin
                                        word = encR(rs, rt, rd, 5'd0, mipsPkg::fnAnd);
                                        res  = a & b;
                                end
                                4'd3: begin
                                        word = encR(rs, rt, rd, 5'd0, mipsPkg::fnOr);
                                        res  = a | b;
                                end
                                4'd4: begin
                                        word = encR(rs, rt, rd, 5'd0, mipsPkg::fnSlt);
                                        res  = {31'd0, $signed(a) < $signed(b)};
                                end
                                4'd5: begin
                                        word = encR(5'd0, rt, rd, sh, mipsPkg::fnSll);
                                        res  = b << sh;
                                end
                                4'd6, 4'd7: begin
                                        word = encI(mipsPkg::opAddiu, rs, rt, imm);
                                        res  = a + {{16{imm[15]}}, imm};
                                        dest = rt;
                                end
                                4'd8: begin
                                        word = encI(mipsPkg::opAndi, rs, rt, imm);
                                        res  = a & {16'd0, imm};
                                        dest = rt;
                                end
                                4'd9: begin
                                        word = encI(mipsPkg::opOri, rs, rt, imm);
                                        res  = a | {16'd0, imm};
                                        dest = rt;
                                end
                                // Load back the most recent store
                                4'd10: begin
                                        word = encI(mipsPkg::opLw, 5'd0, rt, lastSw[15:0]);
                                        res  = dmemM[lastSw[6:2]];
                                        dest = rt;
                                end
                                4'd11, 4'd12: begin
                                        word = encI(mipsPkg::opSw, 5'd0, rt, addr[15:0]);
                                        wr   = 1'b0;
                                        st   = 1'b1;
                                end
                                4'd13: begin
                                        word  = encI(mipsPkg::opBeq, rs, rt, 16'(4 * (m - k) - 1));
                                        wr    = 1'b0;
                                        taken = (a == b);
                                end
                                4'd14: begin
                                        word  = encI(mipsPkg::opBne, rs, rt, 16'(4 * (m - k) - 1));
                                        wr    = 1'b0;
                                        taken = (a != b);
                                end
                                default: begin
                                        // j or jal, picked by one spare bit
                                        word  = encJ(rd[0] ? mipsPkg::opJal : mipsPkg::opJ,
                                                     26'(4 * m));
                                        taken = 1'b1;
                                        wr    = rd[0];
                                        dest  = 5'd31;
                                        res   = 32'(16 * k + 4);
                                end
                        endcase
                        prog[4 * k] = word;
                        // Skipped slots leave no trace in the model
                        if (k == nextSlot) begin
                                if (wr && dest != 5'd0) begin
                                        regsM[dest] = res;
                                        w.dest      = dest;
                                        w.value     = res;
                                        expQ.push_back(w);
                                end
                                if (st) begin
                                        dmemM[addr[6:2]] = b;
                                        lastSw           = addr;
                                        haveSw           = 1'b1;
                                end
                                nextSlot = taken ? m : k + 1;
                        end
                end
                // Halt loop
                haltAddr        = 32'(16 * Slots);
                prog[4 * Slots] = encJ(mipsPkg::opJ, 26'(4 * Slots));
        endtask

        //////////////////////////////
        // Writeback checks
        //////////////////////////////

        // Front of queue latched mid-cycle, consumed on a write
        always @(negedge clk) begin
                chkAvail = (expQ.size() != 0);
                if (chkAvail) begin
                        chk = expQ[0];
                        if (writeValid) begin
                                void'(expQ.pop_front());
                        end
                end
        end

        idleQuiet: assert property (@(posedge clk) disable iff (rst) !run |-> !writeValid)
                else abortRun("A register write retired while run was low");

        idlePc: assert property (@(posedge clk) disable iff (rst)
                !run |-> (ProgramCounter == `MIPS_RESET_PC))
                else abortRun($sformatf("[ERROR] ProgramCounter expected %h got %h",
                                        `MIPS_RESET_PC, $sampled(ProgramCounter)));

        // Flushed or skipped work must never retire
        noExtraWrite: assert property (@(posedge clk) disable iff (rst) writeValid |-> chkAvail)
                else abortRun("A register write retired with no write expected");

        destMatch: assert property (@(posedge clk) disable iff (rst)
                (writeValid && chkAvail) |-> (writeReg == chk.dest))
                else abortRun($sformatf("[ERROR] writeReg expected %h got %h",
                                        chk.dest, $sampled(writeReg)));

        dataMatch: assert property (@(posedge clk) disable iff (rst)
                (writeValid && chkAvail) |-> (WriteData == chk.value))
                else abortRun($sformatf("[ERROR] WriteData expected %h got %h",
                                        chk.value, $sampled(WriteData)));

        // Watchdog
        initial begin
                repeat (WatchCycles) @(posedge clk);
                abortRun("The program did not reach its halt loop before the time limit");
        end

        //////////////////////////////
        // Main sequence
        //////////////////////////////
        initial begin
                rst      = 1'b1;
                run      = 1'b0;
                imemWe   = 1'b0;
                imemAddr = '0;
                imemData = '0;
                chkAvail = 1'b0;
                chk      = '0;
                haltSeen = 0;
                lfsr     = 32'h2cb3_e496;
                buildProgram();
                repeat (10) @(negedge clk);
                rst = 1'b0;
                // Load the whole image, nops past the halt
                for (int i = 0; i < `MIPS_IMEM_WORDS; i++) begin
                        @(negedge clk);
                        imemWe   = 1'b1;
                        imemAddr = i[5:0];
                        imemData = prog[i];
                end
                @(negedge clk);
                imemWe = 1'b0;
                repeat (3) @(negedge clk);
                run = 1'b1;
                // Halt loop revisits its address every four cycles
                while (haltSeen < 3) begin
                        @(negedge clk);
                        if (expQ.size() == 0 && ProgramCounter == haltAddr) begin
                                haltSeen++;
                        end
                end
                if (expQ.size() == 0 && !writeValid) begin
                        $display("TB PASSED");
                        $finish;
                end else begin
                        abortRun("Expected register writes remain after the halt loop");
                end
        end

endmodule

// ==== mipsTop.sv ====
`timescale 1ns/1ps

module mipsTop (
        input  logic        clk,
        input  logic        rst,
        input  logic        run,
        input  logic        imemWe,
        input  logic [5:0]  imemAddr,
        input  logic [31:0] imemData,
        output logic [31:0] ProgramCounter,
        output logic [31:0] WriteData,
        output logic        writeValid,
        output logic [4:0]  writeReg
);

        mipsPkg::ifIdT  ifD;
        mipsPkg::ifIdT  ifQ;
        mipsPkg::idExT  idD;
        mipsPkg::idExT  idQ;
        mipsPkg::exMemT exD;
        mipsPkg::exMemT exQ;
        mipsPkg::memWbT memD;
        mipsPkg::memWbT memQ;
        logic           redirect;
        logic [31:0]    redirectPc;

        //////////////////////////////
        // Fetch
        //////////////////////////////
        fetchUnit i_fetchUnit (
                .clk(clk), .rst(rst), .run(run),
                .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
                .redirect(redirect), .redirectPc(redirectPc),
                .ProgramCounter(ProgramCounter), .ifOut(ifD)
        );

        // Younger three stages squashed on redirect
        pipeReg #(.payloadT(mipsPkg::ifIdT)) ifIdReg (
                .clk(clk), .rst(rst), .flush(redirect), .d(ifD), .q(ifQ)
        );

        // Decode, regfile written from WB
        decodeUnit i_decodeUnit (
                .clk(clk), .rst(rst), .ifIn(ifQ),
                .wbWrite(memQ.regWrite), .wbReg(memQ.writeReg), .wbData(WriteData),
                .idOut(idD)
        );

        pipeReg #(.payloadT(mipsPkg::idExT)) idExReg (
                .clk(clk), .rst(rst), .flush(redirect), .d(idD), .q(idQ)
        );

        executeUnit i_executeUnit (
                .idIn(idQ), .exOut(exD)
        );

        pipeReg #(.payloadT(mipsPkg::exMemT)) exMemReg (
                .clk(clk), .rst(rst), .flush(redirect), .d(exD), .q(exQ)
        );

        // Memory stage owns the redirect
        memoryUnit i_memoryUnit (
                .clk(clk), .rst(rst), .memIn(exQ), .memOut(memD),
                .redirect(redirect), .redirectPc(redirectPc)
        );

        // Branch in MEM is older, never flushed
        pipeReg #(.payloadT(mipsPkg::memWbT)) memWbReg (
                .clk(clk), .rst(rst), .flush(1'b0), .d(memD), .q(memQ)
        );

        //////////////////////////////
        // Writeback select
        //////////////////////////////
        always_comb begin
                case (memQ.wbSel)
                        mipsPkg::wbMem: WriteData = memQ.memData;
                        // Return address for jal
                        mipsPkg::wbPc:  WriteData = memQ.pcPlus4;
                        default:        WriteData = memQ.aluResult;
                endcase
        end

        assign writeValid = memQ.regWrite;
        assign writeReg   = memQ.writeReg;

endmodule

// ==== mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

//////////////////////////////
// Memory sizing
//////////////////////////////

// Instruction memory depth in words, matches the 6-bit load address
`define MIPS_IMEM_WORDS 64

// Data memory depth in words
`define MIPS_DMEM_WORDS 32

//////////////////////////////
// Fetch
//////////////////////////////

// First fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== pipeReg.sv ====
`timescale 1ns/1ps

module pipeReg #(
        parameter type payloadT = mipsPkg::ifIdT
) (
        input  logic    clk,
        input  logic    rst,
        input  logic    flush,
        input  payloadT d,
        output payloadT q
);

        // Bubble is the all-zero payload
        always_ff @(posedge clk) begin
                if (rst || flush) begin
                        q <= '0;
                end else begin
                        q <= d;
                end
        end

endmodule

// ==== vlog.f ====
+incdir+.
mipsPkg.sv
pipeReg.sv
fetchUnit.sv
decodeUnit.sv
executeUnit.sv
memoryUnit.sv
mipsTop.sv
mipsTb.sv
